// ==== logic/word_game_pkg.sv ====
// word guessing game shared definitions
// character, word and row types, the stage structs and the game constants
package word_game_pkg;

    localparam int WORD_LEN   = 5; // letters in the secret word
    localparam int MAX_MISSES = 6; // misses that lose the game

    typedef logic [7:0]              char_t;
    typedef logic [WORD_LEN*8-1:0]   word_t;     // leftmost letter in the top byte
    typedef logic [MAX_MISSES*8-1:0] misses_t;   // newest miss on the left
    typedef logic [127:0]            row_t;      // sixteen display characters
    typedef logic [WORD_LEN-1:0]     pos_mask_t; // bit 4 is the leftmost letter
    typedef logic [2:0]              count_t;

    localparam char_t       CHAR_BLANK   = 8'h5F; // underscore
    localparam char_t       CHAR_SPACE   = 8'h20;
    localparam logic [23:0] TEXT_WIN     = "Win";
    localparam logic [31:0] TEXT_LOSE    = "Lose";
    localparam word_t       WORD_BLANK   = {WORD_LEN{CHAR_BLANK}};
    localparam misses_t     MISSES_BLANK = {MAX_MISSES{CHAR_BLANK}};
    localparam row_t        ROW_SPACES   = {16{CHAR_SPACE}};

    // stage 1 to stage 2
    typedef struct packed {
        logic  guess;   // one cycle per guessed letter
        char_t letter;
        word_t secret;
        logic  playing; // high in the guessing phase
    } entry_t;

    // stage 2 to stage 3
    typedef struct packed {
        logic      guess;
        char_t     letter;
        word_t     secret;
        logic      playing;
        pos_mask_t hits;     // positions holding the letter
        logic      mistake;  // letter not in the word
        count_t    revealed;
        count_t    misses;
    } check_t;

    localparam entry_t ENTRY_IDLE = '{guess: 1'b0, letter: CHAR_SPACE,
                                      secret: WORD_BLANK, playing: 1'b0};
    localparam check_t CHECK_IDLE = '{guess: 1'b0, letter: CHAR_SPACE,
                                      secret: WORD_BLANK, playing: 1'b0,
                                      hits: '0, mistake: 1'b0,
                                      revealed: '0, misses: '0};

endpackage

// ==== logic/word_entry.sv ====
// word entry, stage 1 of the game pipeline
// collects the secret word during setup, then turns letter strobes
// into guess events once the game is started
module word_entry (
    input  logic                  clk,
    input  logic                  nRst,
    input  word_game_pkg::char_t  switch_letter,
    input  logic                  letter_strobe,
    input  logic                  start,
    input  logic                  new_game,
    output word_game_pkg::entry_t entry,
    output word_game_pkg::char_t  shown_letter
);
    import word_game_pkg::*;

    count_t letter_count; // letters typed in setup
    logic   word_full;

    assign word_full = (letter_count == count_t'(WORD_LEN));

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            entry        <= ENTRY_IDLE;
            letter_count <= '0;
        end else if (new_game) begin
            entry        <= ENTRY_IDLE; // back to setup
            letter_count <= '0;
        end else begin
            entry.guess <= letter_strobe & entry.playing;
            if (letter_strobe) begin
                entry.letter <= switch_letter;
            end

            if (!entry.playing) begin
                // shift in from the right, extra letters are ignored
                if (letter_strobe && !word_full) begin
                    entry.secret <= {entry.secret[31:0], switch_letter};
                    letter_count <= letter_count + 1'b1;
                end
                if (start && word_full) begin
                    entry.playing <= 1'b1; // early start is ignored
                end
            end
        end
    end

    // letter under the switches, for the setup row
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            shown_letter <= CHAR_SPACE;
        end else begin
            shown_letter <= switch_letter;
        end
    end

endmodule

// ==== logic/guess_check.sv ====
// guess checker, stage 2 of the game pipeline
// matches each guess against the secret word and keeps the found
// positions, the revealed count and the miss count
module guess_check (
    input  logic                  clk,
    input  logic                  nRst,
    input  word_game_pkg::entry_t entry,
    input  word_game_pkg::char_t  shown_letter_in,
    input  logic                  new_game,
    output word_game_pkg::check_t check,
    output word_game_pkg::char_t  shown_letter
);
    import word_game_pkg::*;

    pos_mask_t hits;          // positions matching this letter
    pos_mask_t found;         // positions found so far
    pos_mask_t found_next;
    count_t    revealed_next;
    logic      over;          // game already won or lost
    logic      accept;
    logic      miss;

    function automatic count_t count_ones(input pos_mask_t mask);
        count_t total;
        total = '0;
        for (int i = 0; i < WORD_LEN; i++) begin
            total = total + count_t'(mask[i]);
        end
        return total;
    endfunction

    always_comb begin
        for (int i = 0; i < WORD_LEN; i++) begin
            hits[i] = (entry.letter == entry.secret[i*8 +: 8]);
        end
    end

    assign over = (check.revealed == count_t'(WORD_LEN)) ||
                  (check.misses == count_t'(MAX_MISSES));
    assign accept        = entry.guess & entry.playing & ~over;
    assign miss          = accept & (hits == '0);
    assign found_next    = accept ? (found | hits) : found;
    assign revealed_next = count_ones(found_next);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            found <= '0;
            check <= CHECK_IDLE;
        end else if (new_game) begin
            found <= '0;
            check <= CHECK_IDLE;
        end else begin
            found          <= found_next;
            check.guess    <= accept; // dropped once the game is over
            check.letter   <= entry.letter;
            check.secret   <= entry.secret;
            check.playing  <= entry.playing;
            check.hits     <= accept ? hits : '0;
            check.mistake  <= miss;
            check.revealed <= revealed_next;
            check.misses   <= check.misses + count_t'(miss);
        end
    end

    // setup letter follows the same delay as the word
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            shown_letter <= CHAR_SPACE;
        end else begin
            shown_letter <= shown_letter_in;
        end
    end

endmodule

// ==== logic/host_display.sv ====
// host display, stage 3 of the game pipeline
// keeps the revealed word and the miss list and lays out the two
// sixteen-character rows for setup, play, win and lose
module host_display (
    input  logic                  clk,
    input  logic                  nRst,
    input  word_game_pkg::check_t check,
    input  word_game_pkg::char_t  shown_letter,
    input  logic                  new_game,
    output word_game_pkg::row_t   top_row,
    output word_game_pkg::row_t   bottom_row
);
    import word_game_pkg::*;

    word_t   word_q;      // revealed letters, blanks elsewhere
    word_t   word_next;
    misses_t miss_q;      // recent wrong letters
    misses_t miss_next;
    logic    hold_blank;  // rows kept empty after a new game
    logic    blank_next;
    logic    won;
    logic    lost;
    row_t    secret_row;
    row_t    top_next;
    row_t    bottom_next;

    always_comb begin
        word_next = word_q;
        miss_next = miss_q;
        if (new_game) begin
            word_next = WORD_BLANK;
            miss_next = MISSES_BLANK;
        end else begin
            if (check.guess) begin
                for (int i = 0; i < WORD_LEN; i++) begin
                    // a position only ever fills once
                    if (check.hits[i] && word_q[i*8 +: 8] == CHAR_BLANK) begin
                        word_next[i*8 +: 8] = check.letter;
                    end
                end
            end
            if (check.mistake) begin
                miss_next = {check.letter, miss_q[47:8]}; // newest on the left
            end
        end
    end

    // blank until setup typing or a start reaches this stage
    assign blank_next = new_game |
                        (hold_blank & (check.secret == WORD_BLANK) & ~check.playing);

    assign won  = check.playing & (check.revealed == count_t'(WORD_LEN));
    assign lost = check.playing & (check.misses == count_t'(MAX_MISSES));

    assign secret_row = {{6{CHAR_SPACE}}, check.secret, {5{CHAR_SPACE}}};

    always_comb begin
        if (blank_next) begin
            top_next    = ROW_SPACES;
            bottom_next = ROW_SPACES;
        end else if (!check.playing) begin
            top_next    = {{7{CHAR_SPACE}}, shown_letter, {8{CHAR_SPACE}}};
            bottom_next = secret_row;
        end else if (won) begin
            top_next    = {{7{CHAR_SPACE}}, TEXT_WIN, {6{CHAR_SPACE}}};
            bottom_next = secret_row;
        end else if (lost) begin
            top_next    = {{6{CHAR_SPACE}}, TEXT_LOSE, {6{CHAR_SPACE}}};
            bottom_next = secret_row;
        end else begin
            // guessing layout
            top_next    = {{6{CHAR_SPACE}}, word_next, {5{CHAR_SPACE}}};
            bottom_next = {{5{CHAR_SPACE}}, miss_next, {5{CHAR_SPACE}}};
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            word_q     <= WORD_BLANK;
            miss_q     <= MISSES_BLANK;
            hold_blank <= 1'b0;
            top_row    <= ROW_SPACES;
            bottom_row <= ROW_SPACES;
        end else begin
            word_q     <= word_next;
            miss_q     <= miss_next;
            hold_blank <= blank_next;
            top_row    <= top_next;
            bottom_row <= bottom_next;
        end
    end

endmodule

// ==== logic/word_game.sv ====
// word guessing game top level
// word entry, guess check and host display chained as a
// three-stage pipeline feeding two display rows
module word_game (
    input  logic                 clk,
    input  logic                 nRst,
    input  word_game_pkg::char_t switch_letter,
    input  logic                 letter_strobe,
    input  logic                 start,
    input  logic                 new_game,
    output word_game_pkg::row_t  top_row,
    output word_game_pkg::row_t  bottom_row
);
    import word_game_pkg::*;

    entry_t entry;        // stage 1 to stage 2
    check_t check;        // stage 2 to stage 3
    char_t  entry_letter; // setup letter, stage 1 copy
    char_t  check_letter; // setup letter, stage 2 copy

    word_entry u_word_entry (
        .clk           (clk),
        .nRst          (nRst),
        .switch_letter (switch_letter),
        .letter_strobe (letter_strobe),
        .start         (start),
        .new_game      (new_game),
        .entry         (entry),
        .shown_letter  (entry_letter)
    );

    guess_check u_guess_check (
        .clk             (clk),
        .nRst            (nRst),
        .entry           (entry),
        .shown_letter_in (entry_letter),
        .new_game        (new_game),
        .check           (check),
        .shown_letter    (check_letter)
    );

    host_display u_host_display (
        .clk          (clk),
        .nRst         (nRst),
        .check        (check),
        .shown_letter (check_letter),
        .new_game     (new_game),
        .top_row      (top_row),
        .bottom_row   (bottom_row)
    );

endmodule

// ==== test/tb_clock.sv ====
// testbench clock source
// free-running clock with a period of 4 time units
module tb_clock (
    output logic clk
);
    localparam int HALF_PERIOD = 2;

    initial begin
        clk = 1'b0;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

// ==== test/tb_word_game.sv ====
// testbench for the word guessing game
// drives setup letters, starts, guesses and new games, and checks
// both display rows against a game model kept in the testbench
module tb_word_game;
    import word_game_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int EVENT_COUNT  = 49; // pulses and idle checks below
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 40 * EVENT_COUNT;

    typedef struct packed {
        row_t top;
        row_t bottom;
    } rows_t;

    logic  clk;
    logic  nRst;
    char_t switch_letter;
    logic  letter_strobe;
    logic  start;
    logic  new_game;
    row_t  top_row;
    row_t  bottom_row;

    char_t exp_switch;
    char_t exp_secret [WORD_LEN];   // index 0 is the leftmost letter
    logic  exp_found [WORD_LEN];
    char_t exp_misses [MAX_MISSES]; // index 0 is the newest miss
    int    exp_count;               // letters typed in setup
    int    exp_miss_count;
    logic  exp_playing;
    logic  exp_blank;               // rows cleared by a new game

    char_t rand_word [WORD_LEN];
    int    order [WORD_LEN];
    int    seed;
    int    error_count;
    int    cycle_count;
    rows_t want;
    event  check_req;
    event  check_done;

    tb_clock u_tb_clock (
        .clk (clk)
    );

    word_game u_word_game (
        .clk           (clk),
        .nRst          (nRst),
        .switch_letter (switch_letter),
        .letter_strobe (letter_strobe),
        .start         (start),
        .new_game      (new_game),
        .top_row       (top_row),
        .bottom_row    (bottom_row)
    );

    function automatic int found_total();
        int total;
        total = 0;
        for (int i = 0; i < WORD_LEN; i++) begin
            if (exp_found[i]) begin
                total++;
            end
        end
        return total;
    endfunction

    function automatic logic game_over();
        return (found_total() == WORD_LEN) || (exp_miss_count == MAX_MISSES);
    endfunction

    // column 0 is the leftmost character of a row
    function automatic row_t put_char(input row_t row, input int col, input char_t ch);
        row_t result;
        result = row;
        result[(15 - col) * 8 +: 8] = ch;
        return result;
    endfunction

    function automatic row_t write_text(input row_t row, input int col, input string text);
        row_t result;
        result = row;
        for (int i = 0; i < text.len(); i++) begin
            result = put_char(result, col + i, text[i]);
        end
        return result;
    endfunction

    // both rows as the game model says they should look
    function automatic rows_t expected_rows();
        rows_t rows;
        rows.top    = {16{CHAR_SPACE}};
        rows.bottom = {16{CHAR_SPACE}};
        if (!exp_blank) begin
            if (!exp_playing || game_over()) begin
                for (int i = 0; i < WORD_LEN; i++) begin
                    rows.bottom = put_char(rows.bottom, 6 + i, exp_secret[i]);
                end
            end
            if (!exp_playing) begin
                rows.top = put_char(rows.top, 7, exp_switch);
            end else if (found_total() == WORD_LEN) begin
                rows.top = write_text(rows.top, 7, "Win");
            end else if (exp_miss_count == MAX_MISSES) begin
                rows.top = write_text(rows.top, 6, "Lose");
            end else begin
                for (int i = 0; i < WORD_LEN; i++) begin
                    rows.top = put_char(rows.top, 6 + i,
                                        exp_found[i] ? exp_secret[i] : CHAR_BLANK);
                end
                for (int i = 0; i < MAX_MISSES; i++) begin
                    rows.bottom = put_char(rows.bottom, 5 + i, exp_misses[i]);
                end
            end
        end
        return rows;
    endfunction

    task automatic clear_model();
        exp_count      = 0;
        exp_miss_count = 0;
        exp_playing    = 1'b0;
        for (int i = 0; i < WORD_LEN; i++) begin
            exp_secret[i] = CHAR_BLANK;
            exp_found[i]  = 1'b0;
        end
        for (int i = 0; i < MAX_MISSES; i++) begin
            exp_misses[i] = CHAR_BLANK;
        end
    endtask

    task automatic apply_letter(input char_t letter);
        logic hit;
        hit        = 1'b0;
        exp_switch = letter;
        if (!exp_playing) begin
            if (exp_count < WORD_LEN) begin
                for (int i = 0; i < WORD_LEN - 1; i++) begin
                    exp_secret[i] = exp_secret[i + 1];
                end
                exp_secret[WORD_LEN - 1] = letter; // enters from the right
                exp_count++;
                exp_blank = 1'b0;
            end
        end else if (!game_over()) begin
            for (int i = 0; i < WORD_LEN; i++) begin
                if (exp_secret[i] == letter) begin
                    exp_found[i] = 1'b1;
                    hit          = 1'b1;
                end
            end
            if (!hit) begin
                for (int i = MAX_MISSES - 1; i > 0; i--) begin
                    exp_misses[i] = exp_misses[i - 1];
                end
                exp_misses[0] = letter;
                exp_miss_count++;
            end
        end
    endtask

    task automatic check_row(input string name, input row_t expected, input row_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH at %0t: %s expected \"%s\" got \"%s\"",
                     $time, name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "display row differs from the game model");
        end
    endtask

    // one pulse after the clock edge, then wait for its row check
    task automatic drive_pulse(input logic strobe_in, input logic start_in,
                               input logic new_in, input char_t letter);
        @(posedge clk);
        #1;
        switch_letter = letter;
        letter_strobe = strobe_in;
        start         = start_in;
        new_game      = new_in;
        -> check_req;
        @(posedge clk);
        #1;
        letter_strobe = 1'b0;
        start         = 1'b0;
        new_game      = 1'b0;
        @(check_done);
    endtask

    task automatic type_letter(input char_t letter);
        apply_letter(letter);
        drive_pulse(1'b1, 1'b0, 1'b0, letter);
    endtask

    task automatic type_word(input string word);
        for (int i = 0; i < word.len(); i++) begin
            type_letter(word[i]);
        end
    endtask

    task automatic press_start();
        if (!exp_playing && exp_count == WORD_LEN) begin
            exp_playing = 1'b1;
        end
        drive_pulse(1'b0, 1'b1, 1'b0, exp_switch);
    endtask

    task automatic press_new_game();
        clear_model();
        exp_blank = 1'b1;
        drive_pulse(1'b0, 1'b0, 1'b1, exp_switch);
    endtask

    task automatic hold_check();
        drive_pulse(1'b0, 1'b0, 1'b0, exp_switch);
    endtask

    function automatic char_t random_letter();
        int unsigned pick;
        pick = $unsigned($random(seed)) % 26;
        return 8'h41 + pick[7:0];
    endfunction

    task automatic pick_random_word();
        char_t letter;
        logic  repeated;
        for (int i = 0; i < WORD_LEN; i++) begin
            do begin
                letter   = random_letter();
                repeated = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (rand_word[j] == letter) begin
                        repeated = 1'b1;
                    end
                end
            end while (repeated);
            rand_word[i] = letter;
        end
    endtask

    task automatic shuffle_order();
        int j;
        int tmp;
        for (int i = 0; i < WORD_LEN; i++) begin
            order[i] = i;
        end
        for (int i = WORD_LEN - 1; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
    endtask

    // rows settle two edges after the edge that samples the pulse
    initial begin
        forever begin
            @(check_req);
            repeat (3) @(posedge clk);
            #2;
            want = expected_rows();
            check_row("top_row", want.top, top_row);
            check_row("bottom_row", want.bottom, bottom_row);
            -> check_done;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
        $display("Done: errors found");
        $fatal(1, "simulation timed out");
    end

    initial begin
        seed          = 32'he0920268;
        error_count   = 0;
        nRst          = 1'b0;
        switch_letter = "A";
        letter_strobe = 1'b0;
        start         = 1'b0;
        new_game      = 1'b0;
        exp_switch    = "A";
        exp_blank     = 1'b0;
        clear_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nRst = 1'b1;

        // setup rows and the start rule
        hold_check();
        type_word("APP");
        press_start();    // only three letters
        type_word("LE");
        type_letter("Z"); // sixth letter
        press_start();

        // double hit, repeat guess, then misses up to a loss
        type_letter("P");
        type_letter("P");
        type_letter("A");
        type_word("ZXQJKW");
        type_letter("E"); // dropped after the loss
        type_letter("M");

        // random word of distinct letters, guessed in random order
        press_new_game();
        hold_check();
        pick_random_word();
        for (int i = 0; i < WORD_LEN; i++) begin
            type_letter(rand_word[i]);
        end
        press_start();
        shuffle_order();
        for (int i = 0; i < WORD_LEN; i++) begin
            type_letter(rand_word[order[i]]);
        end
        type_letter(rand_word[0]); // after the win

        // new game while guessing, then a fresh word
        press_new_game();
        type_word("HOUSE");
        press_start();
        type_letter("O");
        type_letter("T");
        press_new_game();
        type_word("CRANE");

        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "row checks failed");
        end
    end

endmodule

// ==== sim.f ====
logic/word_game_pkg.sv
logic/word_entry.sv
logic/guess_check.sv
logic/host_display.sv
logic/word_game.sv
test/tb_clock.sv
test/tb_word_game.sv

// ==== Makefile ====
# Verilator build and run for the word guessing game

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_word_game
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
